// ==== Bender.yml ====
package:
  name: pipe_ctrl

sources:
  # Design, package first
  - files:
      - PipeCtrlPkg.sv
      - PipeIfs.sv
      - HazardUnit.sv
      - PipeControl.sv
      - StageTracker.sv
      - PipeCtrlTop.sv

  # Testbench
  - target: simulation
    files:
      - PipeCtrlTb.sv

// ==== HazardUnit.sv ====
// Hazard detection on the tracked stage contents
// Load-use stalls against EXE, MEM and MEM2
// Immediate jump in ID and failed branch in EXE

`timescale 1ns/1ps
`default_nettype none

module HazardUnit (
    hazardIf.dst   hz,
    stallReqIf.req rq
);
    import PipeCtrlPkg::*;

    // Valid load in a later stage writing a register that ID reads
    function automatic logic loadUseHit(
        input logic    stValid,
        input logic    stIsLoad,
        input regAddrT stRd,
        input regAddrT rs,
        input regAddrT rt
    );
        logic rdLive;
        logic rdMatch;
        // r0 writes are dropped, so never a dependency
        rdLive  = stValid && stIsLoad && (stRd != '0);
        rdMatch = (stRd == rs) || (stRd == rt);
        return rdLive && rdMatch;
    endfunction

    logic exeHit;
    logic memHit;
    logic mem2Hit;

    // ALU results reach ID through forwarding
    // Only load data arriving late costs a stall
    always_comb begin
        exeHit  = loadUseHit(hz.exeValid, hz.exeIsLoad, hz.exeRd, hz.idRs, hz.idRt);
        memHit  = loadUseHit(hz.memValid, hz.memIsLoad, hz.memRd, hz.idRs, hz.idRt);
        mem2Hit = loadUseHit(hz.mem2Valid, hz.mem2IsLoad, hz.mem2Rd, hz.idRs, hz.idRt);
    end

    // Bubble in ID requests nothing
    assign rq.exDhStall   = hz.idValid && exeHit;
    assign rq.mem1DhStall = hz.idValid && memHit;
    assign rq.mem2DhStall = hz.idValid && mem2Hit;

    // J and JAL resolve in decode
    assign rq.idImmJump = hz.idValid && hz.idIsJump;

    // Branch outcome known in EXE, prediction was wrong
    assign rq.exBranchFail = hz.exeValid && hz.exeMispredict;

endmodule

`default_nettype wire

// ==== PipeControl.sv ====
// Fixed priority pipeline controller
// Per-stage write enables and flushes
// Write disables, cache request and cache stall controls

`timescale 1ns/1ps
`default_nettype none

module PipeControl (
    input  logic   clk,
    input  logic   rstN,
    input  logic   excFlush,
    input  logic   iTlbStall,
    input  logic   dTlbStall,
    input  logic   icacheBusy,
    input  logic   dcacheBusy,
    input  logic   divMulBusy,
    stallReqIf.ctl rq,
    pipeCtrlIf.ctl pc
);
    import PipeCtrlPkg::*;

    logic     dSideStall;
    logic     iSideStall;
    logic     excActive;
    logic     anyDhStall;
    stageVecT wr;
    stageVecT flush;
    logic     idDisWr;
    logic     memDisWr;
    logic     wbDisWr;
    logic     icacheFlush;
    logic     iCacheStall;
    logic     dCacheStall;

    assign dSideStall = dTlbStall || dcacheBusy;
    assign iSideStall = iTlbStall || icacheBusy;
    assign excActive  = (excFlush == flushEnable);
    assign anyDhStall = rq.exDhStall || rq.mem1DhStall || rq.mem2DhStall;

    always_comb begin
        // Unnamed stages and signals stay 0
        wr          = '0;
        flush       = '0;
        idDisWr     = 1'b0;
        memDisWr    = 1'b0;
        wbDisWr     = 1'b0;
        icacheFlush = 1'b0;
        iCacheStall = 1'b0;
        dCacheStall = 1'b0;
        // D side, I side and mul/div freeze give the same row
        if (dSideStall || iSideStall || divMulBusy) begin
            memDisWr    = 1'b1;
            wbDisWr     = 1'b1;
            iCacheStall = 1'b1;
            dCacheStall = 1'b1;
        end else if (excActive) begin
            // Redirect to the handler, older instructions drain
            wr[stPreIf] = 1'b1;
            wr[stMem2]  = 1'b1;
            wr[stWb]    = 1'b1;
            flush[stIf]  = 1'b1;
            flush[stId]  = 1'b1;
            flush[stExe] = 1'b1;
            flush[stMem] = 1'b1;
            memDisWr    = 1'b1;
            icacheFlush = 1'b1;
        end else if (rq.mem2DhStall) begin
            // Load leaves MEM2, bubble behind it
            wr[stMem2]    = 1'b1;
            wr[stWb]      = 1'b1;
            flush[stMem2] = 1'b1;
            memDisWr      = 1'b1;
            iCacheStall   = 1'b1;
        end else if (rq.mem1DhStall) begin
            wr[stMem]    = 1'b1;
            wr[stMem2]   = 1'b1;
            wr[stWb]     = 1'b1;
            flush[stMem] = 1'b1;
            iCacheStall  = 1'b1;
        end else if (rq.exDhStall) begin
            // ID holds, bubble into EXE
            wr[stExe]    = 1'b1;
            wr[stMem]    = 1'b1;
            wr[stMem2]   = 1'b1;
            wr[stWb]     = 1'b1;
            flush[stExe] = 1'b1;
            idDisWr      = 1'b1;
            iCacheStall  = 1'b1;
        end else if (rq.exBranchFail) begin
            // Wrong path in IF and ID
            wr[stPreIf] = 1'b1;
            wr[stExe]   = 1'b1;
            wr[stMem]   = 1'b1;
            wr[stMem2]  = 1'b1;
            wr[stWb]    = 1'b1;
            flush[stIf] = 1'b1;
            flush[stId] = 1'b1;
            icacheFlush = 1'b1;
        end else if (rq.idImmJump) begin
            // Delay slot moves IF to ID, IF refetches the target
            wr          = '1;
            wr[stIf]    = 1'b0;
            flush[stIf] = 1'b1;
            icacheFlush = 1'b1;
        end else begin
            wr = '1;
        end
    end

    assign pc.wr          = wr;
    assign pc.flush       = flush;
    assign pc.idDisWr     = idDisWr;
    assign pc.memDisWr    = memDisWr;
    assign pc.wbDisWr     = wbDisWr;
    assign pc.icacheFlush = icacheFlush;
    assign pc.iCacheStall = iCacheStall;
    assign pc.dCacheStall = dCacheStall;

    // HI/LO write blocked outside the priority rows
    assign pc.exeDisWr = excActive || rq.mem1DhStall || divMulBusy;

    // No new fetch while the front end is stalled or redirected
    assign pc.iReqValid = !(excActive || anyDhStall || rq.idImmJump || rq.exBranchFail);
    assign pc.dReqValid = !excActive;

    // Freezes never coexist with a flush at the tracker
    assert property (@(posedge clk) disable iff (!rstN)
        (dSideStall || iSideStall || divMulBusy) |-> (pc.flush == '0));

    // Icache flush only ever drops the instruction in IF
    assert property (@(posedge clk) disable iff (!rstN)
        pc.icacheFlush |-> pc.flush[stIf]);

endmodule

`default_nettype wire

// ==== PipeCtrlPkg.sv ====
// Shared definitions of the pipeline control subsystem
// Register number and per-stage vector types
// Stage index constants and the exception flush level

`default_nettype none

package PipeCtrlPkg;

    // Register file index width
    localparam int regAddrWidth = 5;

    // Register number
    // r0 is hardwired, never a hazard source or destination
    typedef logic [regAddrWidth-1:0] regAddrT;

    // PREIF, IF, ID, EXE, MEM, MEM2, WB
    localparam int numStages = 7;

    // One bit per pipeline stage, indexed by the constants below
    typedef logic [numStages-1:0] stageVecT;

    // Stage indices
    // PREIF computes the next fetch address
    localparam int stPreIf = 0;

    // Instruction fetch, cache data returns here
    localparam int stIf = 1;

    // Decode and register read
    localparam int stId = 2;

    // Execute, branch resolution
    localparam int stExe = 3;

    // First data cache stage
    localparam int stMem = 4;

    // Second data cache stage, load data arrives
    localparam int stMem2 = 5;

    // Writeback, instruction retires here
    localparam int stWb = 6;

    // Active level of the exception flush from CP0
    localparam logic flushEnable = 1'b1;

endpackage

`default_nettype wire

// ==== PipeCtrlTb.sv ====
// Testbench for the pipeline control subsystem
// Cycle model of the stage records and the priority table
// Directed and random stimulus, concurrent checks and a watchdog

`timescale 1ns/1ps
`default_nettype none

module PipeCtrlTb;
    import PipeCtrlPkg::*;

    localparam int TagWidth = 8;
    localparam int clkPeriod = 40;
    localparam int resetCycles = 5;
    localparam int directedCycles = 500;
    localparam int randomCycles = 1500;
    // Generous margin over the expected run length
    localparam int watchdogCycles = 2 * (resetCycles + directedCycles + randomCycles);

    // Event bits {excFlush, divMulBusy, dcacheBusy, dTlbStall, icacheBusy, iTlbStall}
    localparam logic [5:0] evExc = 6'b100000;
    localparam logic [5:0] evDiv = 6'b010000;

    // Rows of the priority table from the highest down
    localparam int rowFreeze = 1;
    localparam int rowExc = 2;
    localparam int rowMem2 = 3;
    localparam int rowMem1 = 4;
    localparam int rowEx = 5;
    localparam int rowBranch = 6;
    localparam int rowJump = 7;
    localparam int rowRun = 8;

    typedef logic [TagWidth-1:0] tagT;

    // Instruction as offered by the fetch source
    typedef struct packed {
        regAddrT rs;
        regAddrT rt;
        regAddrT rd;
        logic    isLoad;
        logic    isJump;
        logic    misp;
    } instT;

    // Model of one stage
    typedef struct packed {
        logic valid;
        tagT  tag;
        instT op;
    } recT;

    logic       clk;
    logic       rstN;
    logic [5:0] evts;
    logic       fetchValid;
    tagT        fetchTag;
    instT       fetchOp;

    logic       fetchAccept;
    logic       retireValid;
    tagT        retireTag;
    regAddrT    retireRd;
    stageVecT   stageWr;
    stageVecT   stageFlush;
    logic       idDisWr;
    logic       exeDisWr;
    logic       memDisWr;
    logic       wbDisWr;
    logic       icacheFlush;
    logic       iReqValid;
    logic       dReqValid;
    logic       iCacheStall;
    logic       dCacheStall;

    PipeCtrlTop #(
        .TagWidth (TagWidth)
    ) dut0 (
        .clk             (clk),
        .rstN            (rstN),
        .excFlush        (evts[5]),
        .divMulBusy      (evts[4]),
        .dcacheBusy      (evts[3]),
        .dTlbStall       (evts[2]),
        .icacheBusy      (evts[1]),
        .iTlbStall       (evts[0]),
        .fetchValid      (fetchValid),
        .fetchTag        (fetchTag),
        .fetchRs         (fetchOp.rs),
        .fetchRt         (fetchOp.rt),
        .fetchRd         (fetchOp.rd),
        .fetchIsLoad     (fetchOp.isLoad),
        .fetchIsJump     (fetchOp.isJump),
        .fetchMispredict (fetchOp.misp),
        .fetchAccept     (fetchAccept),
        .retireValid     (retireValid),
        .retireTag       (retireTag),
        .retireRd        (retireRd),
        .stageWr         (stageWr),
        .stageFlush      (stageFlush),
        .idDisWr         (idDisWr),
        .exeDisWr        (exeDisWr),
        .memDisWr        (memDisWr),
        .wbDisWr         (wbDisWr),
        .icacheFlush     (icacheFlush),
        .iReqValid       (iReqValid),
        .dReqValid       (dReqValid),
        .iCacheStall     (iCacheStall),
        .dCacheStall     (dCacheStall)
    );

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    // Model state
    recT      mdl [stIf:stWb];
    recT      fetchRec;
    tagT      nextTag;
    logic     tookOffer;
    int       rowHits [rowFreeze:rowRun];

    // Expected outputs
    int       row;
    logic     hzEx;
    logic     hzMem;
    logic     hzMem2;
    logic     hzJump;
    logic     hzBranch;
    stageVecT expWr;
    stageVecT expFlush;
    logic     expIdDis;
    logic     expExeDis;
    logic     expMemDis;
    logic     expWbDis;
    logic     expIcFlush;
    logic     expIReq;
    logic     expDReq;
    logic     expIStall;
    logic     expDStall;
    logic     expAccept;
    logic     expRetire;
    tagT      expRetTag;
    regAddrT  expRetRd;

    assign fetchRec = {fetchValid, fetchTag, fetchOp};

    // Load in a later stage whose rd is read by the instruction in ID
    function automatic logic loadFeedsId(input recT prod, input recT cons);
        if (!cons.valid || !prod.valid || !prod.op.isLoad) begin
            return 1'b0;
        end
        if (prod.op.rd == 5'd0) begin
            return 1'b0;
        end
        return (prod.op.rd == cons.op.rs) || (prod.op.rd == cons.op.rt);
    endfunction

    always_comb begin
        hzEx     = loadFeedsId(mdl[stExe], mdl[stId]);
        hzMem    = loadFeedsId(mdl[stMem], mdl[stId]);
        hzMem2   = loadFeedsId(mdl[stMem2], mdl[stId]);
        hzJump   = mdl[stId].valid && mdl[stId].op.isJump;
        hzBranch = mdl[stExe].valid && mdl[stExe].op.misp;
        if (|evts[4:0]) row = rowFreeze;
        else if (evts[5]) row = rowExc;
        else if (hzMem2) row = rowMem2;
        else if (hzMem) row = rowMem1;
        else if (hzEx) row = rowEx;
        else if (hzBranch) row = rowBranch;
        else if (hzJump) row = rowJump;
        else row = rowRun;
        expWr      = '0;
        expFlush   = '0;
        expIdDis   = 1'b0;
        expMemDis  = 1'b0;
        expWbDis   = 1'b0;
        expIcFlush = 1'b0;
        expIStall  = 1'b0;
        expDStall  = 1'b0;
        // Vectors read WB down to PREIF
        case (row)
            rowFreeze: begin
                expMemDis = 1'b1;
                expWbDis  = 1'b1;
                expIStall = 1'b1;
                expDStall = 1'b1;
            end
            rowExc: begin
                expWr      = 7'b1100001;
                expFlush   = 7'b0011110;
                expMemDis  = 1'b1;
                expIcFlush = 1'b1;
            end
            rowMem2: begin
                expWr     = 7'b1100000;
                expFlush  = 7'b0100000;
                expMemDis = 1'b1;
                expIStall = 1'b1;
            end
            rowMem1: begin
                expWr     = 7'b1110000;
                expFlush  = 7'b0010000;
                expIStall = 1'b1;
            end
            rowEx: begin
                expWr     = 7'b1111000;
                expFlush  = 7'b0001000;
                expIdDis  = 1'b1;
                expIStall = 1'b1;
            end
            rowBranch: begin
                expWr      = 7'b1111001;
                expFlush   = 7'b0000110;
                expIcFlush = 1'b1;
            end
            rowJump: begin
                // Delay slot still moves on to ID
                expWr      = 7'b1111101;
                expFlush   = 7'b0000010;
                expIcFlush = 1'b1;
            end
            default: expWr = '1;
        endcase
        expExeDis = evts[5] || hzMem || evts[4];
        expIReq   = !(evts[5] || hzEx || hzMem || hzMem2 || hzJump || hzBranch);
        expDReq   = !evts[5];
        expAccept = expWr[stIf] && !expFlush[stIf];
        expRetire = mdl[stWb].valid && expWr[stWb];
        expRetTag = mdl[stWb].tag;
        expRetRd  = mdl[stWb].op.rd;
    end

    // Stage advance where flush wins over write
    always @(posedge clk) begin
        if (!rstN) begin
            for (int s = stIf; s <= stWb; s++) begin
                mdl[s] <= '0;
            end
            for (int r = rowFreeze; r <= rowRun; r++) begin
                rowHits[r] <= 0;
            end
            nextTag   <= '0;
            tookOffer <= 1'b0;
        end else begin
            if (expFlush[stIf]) mdl[stIf].valid <= 1'b0;
            else if (expWr[stIf]) mdl[stIf] <= fetchRec;
            for (int s = stId; s <= stWb; s++) begin
                if (expFlush[s]) mdl[s].valid <= 1'b0;
                else if (expWr[s]) mdl[s] <= mdl[s-1];
            end
            tookOffer <= expAccept && fetchValid;
            if (expAccept && fetchValid) nextTag <= nextTag + 1'b1;
            rowHits[row] <= rowHits[row] + 1;
        end
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
        failRun($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, want));
    endtask

    // DUT against model with values sampled just before each edge
    assert property (@(posedge clk) disable iff (!rstN) stageWr == expWr)
        else reportMismatch("stageWr", $sampled(stageWr), $sampled(expWr));
    assert property (@(posedge clk) disable iff (!rstN) stageFlush == expFlush)
        else reportMismatch("stageFlush", $sampled(stageFlush), $sampled(expFlush));
    assert property (@(posedge clk) disable iff (!rstN) fetchAccept == expAccept)
        else reportMismatch("fetchAccept", $sampled(fetchAccept), $sampled(expAccept));
    assert property (@(posedge clk) disable iff (!rstN) retireValid == expRetire)
        else reportMismatch("retireValid", $sampled(retireValid), $sampled(expRetire));
    assert property (@(posedge clk) disable iff (!rstN) expRetire |-> retireTag == expRetTag)
        else reportMismatch("retireTag", $sampled(retireTag), $sampled(expRetTag));
    assert property (@(posedge clk) disable iff (!rstN) expRetire |-> retireRd == expRetRd)
        else reportMismatch("retireRd", $sampled(retireRd), $sampled(expRetRd));
    assert property (@(posedge clk) disable iff (!rstN) idDisWr == expIdDis)
        else reportMismatch("idDisWr", $sampled(idDisWr), $sampled(expIdDis));
    assert property (@(posedge clk) disable iff (!rstN) exeDisWr == expExeDis)
        else reportMismatch("exeDisWr", $sampled(exeDisWr), $sampled(expExeDis));
    assert property (@(posedge clk) disable iff (!rstN) memDisWr == expMemDis)
        else reportMismatch("memDisWr", $sampled(memDisWr), $sampled(expMemDis));
    assert property (@(posedge clk) disable iff (!rstN) wbDisWr == expWbDis)
        else reportMismatch("wbDisWr", $sampled(wbDisWr), $sampled(expWbDis));
    assert property (@(posedge clk) disable iff (!rstN) icacheFlush == expIcFlush)
        else reportMismatch("icacheFlush", $sampled(icacheFlush), $sampled(expIcFlush));
    assert property (@(posedge clk) disable iff (!rstN) iReqValid == expIReq)
        else reportMismatch("iReqValid", $sampled(iReqValid), $sampled(expIReq));
    assert property (@(posedge clk) disable iff (!rstN) dReqValid == expDReq)
        else reportMismatch("dReqValid", $sampled(dReqValid), $sampled(expDReq));
    assert property (@(posedge clk) disable iff (!rstN) iCacheStall == expIStall)
        else reportMismatch("iCacheStall", $sampled(iCacheStall), $sampled(expIStall));
    assert property (@(posedge clk) disable iff (!rstN) dCacheStall == expDStall)
        else reportMismatch("dCacheStall", $sampled(dCacheStall), $sampled(expDStall));

    // Program waiting to be fetched with its head on offer
    instT progQ [$];

    task automatic driveFetch();
        if (progQ.size() > 0) begin
            fetchValid = 1'b1;
            fetchOp    = progQ[0];
        end else begin
            fetchValid = 1'b0;
        end
        fetchTag = nextTag;
    endtask

    // One clock, then offer the next instruction if the last one went in
    task automatic cycle();
        @(posedge clk);
        #2;
        if (tookOffer && progQ.size() > 0) void'(progQ.pop_front());
        driveFetch();
    endtask

    task automatic push(input int rs, input int rt, input int rd,
                        input int isLoad, input int isJump, input int misp);
        instT op;
        op.rs     = regAddrT'(rs);
        op.rt     = regAddrT'(rt);
        op.rd     = regAddrT'(rd);
        op.isLoad = (isLoad != 0);
        op.isJump = (isJump != 0);
        op.misp   = (misp != 0);
        progQ.push_back(op);
        driveFetch();
    endtask

    task automatic hold(input logic [5:0] ev, input int n);
        for (int i = 0; i < n; i++) begin
            evts = ev;
            cycle();
        end
        evts = '0;
    endtask

    // Any stage of the model still holds an instruction
    function automatic logic pipeBusy();
        logic busy;
        busy = 1'b0;
        for (int s = stIf; s <= stWb; s++) begin
            busy = busy | mdl[s].valid;
        end
        return busy;
    endfunction

    // Fetch everything queued, then wait for the pipe to empty
    task automatic drain();
        while (progQ.size() > 0 || pipeBusy()) begin
            cycle();
        end
    endtask

    task automatic randomPhase();
        logic [5:0] ev;
        for (int i = 0; i < randomCycles; i++) begin
            case ($urandom_range(0, 15))
                0: ev = evExc;
                1: ev = 6'($urandom_range(1, 63));
                2: ev = 6'(1 << $urandom_range(0, 4));
                default: ev = '0;
            endcase
            // Small registers so loads and uses collide often
            if (progQ.size() < 2 && $urandom_range(0, 3) != 0) begin
                push($urandom_range(0, 7), $urandom_range(0, 7), $urandom_range(0, 7),
                     $urandom_range(0, 2) == 0, $urandom_range(0, 15) == 0,
                     $urandom_range(0, 15) == 0);
            end
            evts = ev;
            cycle();
        end
        evts = '0;
    endtask

    initial begin
        int missing;
        void'($urandom(32'h7183));
        rstN       = 1'b0;
        evts       = '0;
        fetchValid = 1'b0;
        fetchTag   = '0;
        fetchOp    = '0;
        repeat (resetCycles) @(posedge clk);
        #2;
        rstN = 1'b1;

        // Nothing retires from an empty pipe
        hold('0, 10);
        // Straight-line code
        for (int i = 1; i <= 8; i++) begin
            push(i, i + 1, 8 + i, 0, 0, 0);
        end
        drain();
        // Load-use at distance one, two and three
        push(1, 2, 5, 1, 0, 0);
        push(5, 0, 6, 0, 0, 0);
        drain();
        push(1, 2, 7, 1, 0, 0);
        push(3, 4, 8, 0, 0, 0);
        push(0, 7, 9, 0, 0, 0);
        drain();
        push(1, 2, 10, 1, 0, 0);
        push(3, 4, 8, 0, 0, 0);
        push(3, 4, 8, 0, 0, 0);
        push(10, 10, 11, 0, 0, 0);
        drain();
        // Load to r0 never stalls
        push(1, 2, 0, 1, 0, 0);
        push(0, 0, 3, 0, 0, 0);
        drain();
        // Each freeze source against an exception, then load use, branch and jump
        for (int b = 0; b < 5; b++) begin
            push(1, 2, 12, 1, 0, 0);
            push(12, 3, 4, 0, 0, 1);
            push(5, 6, 7, 0, 1, 0);
            push(1, 1, 1, 0, 0, 0);
            hold('0, 2);
            hold(6'(1 << b) | evExc, 3);
            drain();
        end
        // Exception in the middle of a stream
        for (int i = 0; i < 6; i++) begin
            push(i, i, 16 + i, 0, 0, 0);
        end
        hold('0, 4);
        hold(evExc, 1);
        drain();
        // Failed branch drops IF and ID
        push(1, 2, 3, 0, 0, 1);
        push(4, 5, 6, 0, 0, 0);
        push(7, 8, 9, 0, 0, 0);
        push(10, 11, 12, 0, 0, 0);
        drain();
        // Jump whose delay slot survives
        push(1, 2, 3, 0, 1, 0);
        push(4, 5, 6, 0, 0, 0);
        push(7, 8, 9, 0, 0, 0);
        push(10, 11, 13, 0, 0, 0);
        drain();
        // Mul/div busy alone
        push(1, 2, 3, 0, 0, 0);
        hold(evDiv, 4);
        drain();

        randomPhase();
        drain();

        missing = 0;
        for (int r = rowFreeze; r <= rowRun; r++) begin
            if (rowHits[r] == 0) missing++;
        end
        if (missing == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            failRun($sformatf("%0d rows of the priority table were never reached", missing));
        end
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        failRun("Watchdog expired, the test did not finish in time");
    end

endmodule

`default_nettype wire

// ==== PipeCtrlTop.sv ====
// Top level of the pipeline control subsystem
// Hazard detector, priority controller and stage tracker
// Plain ports on the outside, interfaces inside

`timescale 1ns/1ps
`default_nettype none

module PipeCtrlTop #(
    parameter int TagWidth = 8
) (
    input  logic                  clk,
    input  logic                  rstN,
    // Stall and flush events from the rest of the core
    input  logic                  excFlush,
    input  logic                  iTlbStall,
    input  logic                  dTlbStall,
    input  logic                  icacheBusy,
    input  logic                  dcacheBusy,
    input  logic                  divMulBusy,
    // Fetched instruction offer
    input  logic                  fetchValid,
    input  logic [TagWidth-1:0]   fetchTag,
    input  PipeCtrlPkg::regAddrT  fetchRs,
    input  PipeCtrlPkg::regAddrT  fetchRt,
    input  PipeCtrlPkg::regAddrT  fetchRd,
    input  logic                  fetchIsLoad,
    input  logic                  fetchIsJump,
    input  logic                  fetchMispredict,
    output logic                  fetchAccept,
    // Retirement from WB
    output logic                  retireValid,
    output logic [TagWidth-1:0]   retireTag,
    output PipeCtrlPkg::regAddrT  retireRd,
    // Pipeline controls
    output PipeCtrlPkg::stageVecT stageWr,
    output PipeCtrlPkg::stageVecT stageFlush,
    output logic                  idDisWr,
    output logic                  exeDisWr,
    output logic                  memDisWr,
    output logic                  wbDisWr,
    output logic                  icacheFlush,
    output logic                  iReqValid,
    output logic                  dReqValid,
    output logic                  iCacheStall,
    output logic                  dCacheStall
);

    hazardIf   hzIf ();
    stallReqIf rqIf ();
    pipeCtrlIf pcIf ();

    HazardUnit hazard0 (
        .hz (hzIf.dst),
        .rq (rqIf.req)
    );

    PipeControl ctrl0 (
        .clk        (clk),
        .rstN       (rstN),
        .excFlush   (excFlush),
        .iTlbStall  (iTlbStall),
        .dTlbStall  (dTlbStall),
        .icacheBusy (icacheBusy),
        .dcacheBusy (dcacheBusy),
        .divMulBusy (divMulBusy),
        .rq         (rqIf.ctl),
        .pc         (pcIf.ctl)
    );

    StageTracker #(
        .TagWidth (TagWidth)
    ) tracker0 (
        .clk             (clk),
        .rstN            (rstN),
        .fetchValid      (fetchValid),
        .fetchTag        (fetchTag),
        .fetchRs         (fetchRs),
        .fetchRt         (fetchRt),
        .fetchRd         (fetchRd),
        .fetchIsLoad     (fetchIsLoad),
        .fetchIsJump     (fetchIsJump),
        .fetchMispredict (fetchMispredict),
        .pc              (pcIf.stg),
        .hz              (hzIf.src),
        .fetchAccept     (fetchAccept),
        .retireValid     (retireValid),
        .retireTag       (retireTag),
        .retireRd        (retireRd)
    );

    // Controller outputs to the core
    assign stageWr     = pcIf.wr;
    assign stageFlush  = pcIf.flush;
    assign idDisWr     = pcIf.idDisWr;
    assign exeDisWr    = pcIf.exeDisWr;
    assign memDisWr    = pcIf.memDisWr;
    assign wbDisWr     = pcIf.wbDisWr;
    assign icacheFlush = pcIf.icacheFlush;
    assign iReqValid   = pcIf.iReqValid;
    assign dReqValid   = pcIf.dReqValid;
    assign iCacheStall = pcIf.iCacheStall;
    assign dCacheStall = pcIf.dCacheStall;

endmodule

`default_nettype wire

// ==== PipeIfs.sv ====
// Interfaces between the pipeline control blocks
// hazardIf carries tracked stage contents to the hazard detector
// stallReqIf carries hazard requests to the controller
// pipeCtrlIf carries per-stage and cache controls

`timescale 1ns/1ps
`default_nettype none

interface hazardIf;
    import PipeCtrlPkg::*;

    // Consumer side in ID
    logic    idValid;
    regAddrT idRs;
    regAddrT idRt;
    logic    idIsJump;

    // Producers further down
    logic    exeValid;
    regAddrT exeRd;
    logic    exeIsLoad;
    logic    exeMispredict;
    logic    memValid;
    regAddrT memRd;
    logic    memIsLoad;
    logic    mem2Valid;
    regAddrT mem2Rd;
    logic    mem2IsLoad;

    modport src (output idValid, idRs, idRt, idIsJump, exeValid, exeRd, exeIsLoad,
                 exeMispredict, memValid, memRd, memIsLoad, mem2Valid, mem2Rd, mem2IsLoad);
    modport dst (input idValid, idRs, idRt, idIsJump, exeValid, exeRd, exeIsLoad,
                 exeMispredict, memValid, memRd, memIsLoad, mem2Valid, mem2Rd, mem2IsLoad);
endinterface

interface stallReqIf;
    // Load-use stalls, one per producing stage
    logic exDhStall;
    logic mem1DhStall;
    logic mem2DhStall;
    // Control flow redirects
    logic idImmJump;
    logic exBranchFail;

    modport req (output exDhStall, mem1DhStall, mem2DhStall, idImmJump, exBranchFail);
    modport ctl (input exDhStall, mem1DhStall, mem2DhStall, idImmJump, exBranchFail);
endinterface

interface pipeCtrlIf;
    import PipeCtrlPkg::*;

    stageVecT wr;
    stageVecT flush;
    logic     idDisWr;
    logic     exeDisWr;
    logic     memDisWr;
    logic     wbDisWr;
    logic     icacheFlush;
    logic     iReqValid;
    logic     dReqValid;
    logic     iCacheStall;
    logic     dCacheStall;

    modport ctl (output wr, flush, idDisWr, exeDisWr, memDisWr, wbDisWr, icacheFlush,
                 iReqValid, dReqValid, iCacheStall, dCacheStall);
    // Tracker only needs the stage controls
    modport stg (input wr, flush);
endinterface

`default_nettype wire

// ==== StageTracker.sv ====
// Shadow record of the instruction in each stage, IF through WB
// Stage advance, hold and flush from the controller
// Fetch accept, retire report and hazard view of the stages

`timescale 1ns/1ps
`default_nettype none

module StageTracker #(
    parameter int TagWidth = 8
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  fetchValid,
    input  logic [TagWidth-1:0]   fetchTag,
    input  PipeCtrlPkg::regAddrT  fetchRs,
    input  PipeCtrlPkg::regAddrT  fetchRt,
    input  PipeCtrlPkg::regAddrT  fetchRd,
    input  logic                  fetchIsLoad,
    input  logic                  fetchIsJump,
    input  logic                  fetchMispredict,
    pipeCtrlIf.stg                pc,
    hazardIf.src                  hz,
    output logic                  fetchAccept,
    output logic                  retireValid,
    output logic [TagWidth-1:0]   retireTag,
    output PipeCtrlPkg::regAddrT  retireRd
);
    import PipeCtrlPkg::*;

    // Stage records
    logic [stWb:stIf]    validQ;
    logic [stWb:stIf]    loadQ;
    logic [stWb:stIf]    jumpQ;
    logic [stWb:stIf]    mispQ;
    logic [TagWidth-1:0] tagQ [stIf:stWb];
    regAddrT             rsQ  [stIf:stWb];
    regAddrT             rtQ  [stIf:stWb];
    regAddrT             rdQ  [stIf:stWb];

    // Record each stage would load, the fetch for IF
    logic [stWb:stIf]    validIn;
    logic [stWb:stIf]    loadIn;
    logic [stWb:stIf]    jumpIn;
    logic [stWb:stIf]    mispIn;
    logic [TagWidth-1:0] tagIn [stIf:stWb];
    regAddrT             rsIn  [stIf:stWb];
    regAddrT             rtIn  [stIf:stWb];
    regAddrT             rdIn  [stIf:stWb];

    always_comb begin
        validIn[stIf] = fetchValid;
        loadIn[stIf]  = fetchIsLoad;
        jumpIn[stIf]  = fetchIsJump;
        mispIn[stIf]  = fetchMispredict;
        tagIn[stIf]   = fetchTag;
        rsIn[stIf]    = fetchRs;
        rtIn[stIf]    = fetchRt;
        rdIn[stIf]    = fetchRd;
        // Every later stage takes its predecessor as it was before the edge
        for (int s = stId; s <= stWb; s++) begin
            validIn[s] = validQ[s-1];
            loadIn[s]  = loadQ[s-1];
            jumpIn[s]  = jumpQ[s-1];
            mispIn[s]  = mispQ[s-1];
            tagIn[s]   = tagQ[s-1];
            rsIn[s]    = rsQ[s-1];
            rtIn[s]    = rtQ[s-1];
            rdIn[s]    = rdQ[s-1];
        end
    end

    // Flush beats write, otherwise hold
    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ <= '0;
        end else begin
            for (int s = stIf; s <= stWb; s++) begin
                if (pc.flush[s]) begin
                    validQ[s] <= 1'b0;
                end else if (pc.wr[s]) begin
                    validQ[s] <= validIn[s];
                end
            end
        end
    end

    // Payload, only meaningful under validQ
    always_ff @(posedge clk) begin
        for (int s = stIf; s <= stWb; s++) begin
            if (pc.wr[s] && !pc.flush[s]) begin
                loadQ[s] <= loadIn[s];
                jumpQ[s] <= jumpIn[s];
                mispQ[s] <= mispIn[s];
                tagQ[s]  <= tagIn[s];
                rsQ[s]   <= rsIn[s];
                rtQ[s]   <= rtIn[s];
                rdQ[s]   <= rdIn[s];
            end
        end
    end

    // IF loads without being flushed
    assign fetchAccept = pc.wr[stIf] && !pc.flush[stIf];

    // WB leaves at the edge when its write is on
    assign retireValid = validQ[stWb] && pc.wr[stWb];
    assign retireTag   = tagQ[stWb];
    assign retireRd    = rdQ[stWb];

    assign hz.idValid       = validQ[stId];
    assign hz.idRs          = rsQ[stId];
    assign hz.idRt          = rtQ[stId];
    assign hz.idIsJump      = jumpQ[stId];
    assign hz.exeValid      = validQ[stExe];
    assign hz.exeRd         = rdQ[stExe];
    assign hz.exeIsLoad     = loadQ[stExe];
    assign hz.exeMispredict = mispQ[stExe];
    assign hz.memValid      = validQ[stMem];
    assign hz.memRd         = rdQ[stMem];
    assign hz.memIsLoad     = loadQ[stMem];
    assign hz.mem2Valid     = validQ[stMem2];
    assign hz.mem2Rd        = rdQ[stMem2];
    assign hz.mem2IsLoad    = loadQ[stMem2];

    // A held stage keeps the same instruction
    for (genvar g = stIf; g <= stWb; g++) begin : gHoldChk
        assert property (@(posedge clk) disable iff (!rstN)
            (validQ[g] && !pc.wr[g] && !pc.flush[g]) |=> $stable(tagQ[g]));
    end

endmodule

`default_nettype wire

// ==== sim.f ====
PipeCtrlPkg.sv
PipeIfs.sv
HazardUnit.sv
PipeControl.sv
StageTracker.sv
PipeCtrlTop.sv
PipeCtrlTb.sv
